// File: bench/display_model.svh
////////////////////////////////////////////////////////////
// testbench copy of the latched frame state
////////////////////////////////////////////////////////////

vpos_t      m_vpos;
obj_word_t  m_obj [n_objects];
logic [9:0] m_score;
logic [4:0] m_anim;             // frames since reset
int         m_pcount;           // frames since last parallax step
int         m_poffset;

function automatic void model_reset();
    m_vpos = 10'd384;
    for (int i = 0; i < n_objects; i++) begin
        m_obj[i] = '0;
    end
    m_score   = '0;
    m_anim    = '0;
    m_pcount  = 0;
    m_poffset = 0;
endfunction

// one vsync fall
function automatic void model_frame(input vpos_t vp, input obj_word_t objs [n_objects],
                                    input logic [9:0] sc);
    m_vpos  = vp;
    m_obj   = objs;
    m_score = sc;
    m_anim  = m_anim + 5'd1;
    if (m_pcount == parallax_div - 1) begin
        m_pcount  = 0;
        m_poffset = (m_poffset + 1) % 2048;     // 11 bit offset
    end else begin
        m_pcount = m_pcount + 1;
    end
endfunction

// place is 100, 10 or 1
function automatic logic [3:0] model_digit(input int place);
    int sc;
    sc = (int'(m_score) > 999) ? 999 : int'(m_score);     // clamp
    return 4'((sc / place) % 10);
endfunction

function automatic logic inside_rect(input int h, input int v, input int x, input int y,
                                     input int w, input int hh);
    return (h >= x) && (h < x + w) && (v >= y) && (v < y + hh);
endfunction

// expected pixel, highest layer first
function automatic rgb_t model_pixel(input int h, input int v, input int wave, input int hp);
    int   digs [3];
    int   col;
    int   row;
    int   sx;
    obj_word_t o;
    digs[0] = int'(model_digit(100));
    digs[1] = int'(model_digit(10));
    digs[2] = int'(model_digit(1));
    if (inside_rect(h, v, int'(player_x), int'(m_vpos), player_w, player_h)) begin
        return player_palette[m_anim[4:3]];     // new frame every 8 vsyncs
    end
    for (int i = 0; i < n_objects; i++) begin
        o = m_obj[i];
        if (o != '0 && o.id == obj_coin &&
            inside_rect(h, v, int'(o.x), int'(o.y), coin_w, coin_h)) begin
            return coin_palette[o.frame];
        end
    end
    for (int i = 0; i < n_objects; i++) begin
        o = m_obj[i];
        if (o != '0 && o.id == obj_shark &&
            inside_rect(h, v, int'(o.x), int'(o.y), shark_w, shark_h)) begin
            return shark_rgb;
        end
    end
    for (int i = 0; i < 3; i++) begin
        if (inside_rect(h, v, int'(heart_x[i]), int'(heart_y), heart_w, heart_h)) begin
            return (hp > i) ? heart_full_rgb : heart_empty_rgb;
        end
    end
    for (int i = 0; i < 3; i++) begin
        if (inside_rect(h, v, int'(digit_x[i]), int'(digit_y), digit_w, digit_h)) begin
            col = (h - int'(digit_x[i])) / glyph_cell;
            row = (v - int'(digit_y)) / glyph_cell;
            if (digit_font[digs[i]][14 - (row * 3 + col)]) begin
                return digit_rgb;               // unlit cells fall through
            end
        end
    end
    if (v > wave) begin
        return water_rgb;
    end
    sx = (h + m_poffset) % 1024;                // scrolled x, 10 bit wrap
    return (((sx >> stripe_bit) & 1) != 0) ? sky_dark_rgb : sky_light_rgb;
endfunction

// File: bench/tb_display.sv
`timescale 1ns/1ns

module tb_display
    import display_pkg::*;
();

    // test lengths, watchdog is derived from these
    localparam int score_frames = 16;
    localparam int obj_frames   = 20;
    localparam int obj_pixels   = 300;
    localparam int hud_frames   = 10;
    localparam int hud_pixels   = 200;
    localparam int bg_frames    = 40;
    localparam int bg_pixels    = 60;
    localparam int anim_frames  = 40;
    localparam int anim_pixels  = 20;
    localparam int frame_cycles = 6;        // drain, vsync pulse, latch wait
    localparam int total_cycles = 16 +
        (score_frames + obj_frames + hud_frames + bg_frames + anim_frames) * frame_cycles +
        obj_frames * obj_pixels + hud_frames * hud_pixels +
        bg_frames * bg_pixels + anim_frames * anim_pixels;
    localparam int watchdog_ns  = (total_cycles * 2 + 500) * 10;

    logic       vclock = 1'b0;
    logic       reset;
    hpos_t      hcount;
    vpos_t      vcount;
    logic       vsync;
    vpos_t      p_vpos;
    vpos_t      wave_prof;
    obj_word_t  p_obj [n_objects];
    logic [9:0] score;
    logic [1:0] health;
    rgb_t       p_rgb;
    logic [3:0] d100;
    logic [3:0] d10;
    logic [3:0] d1;
    rgb_t       exp_q [$];                  // predicted pixels in flight

    `include "digit_font.svh"
    `include "display_model.svh"

    display_top #(.n_objects(n_objects)) i_dut (
        .reset     (reset),
        .vclock    (vclock),
        .hcount    (hcount),
        .vcount    (vcount),
        .vsync     (vsync),
        .p_vpos    (p_vpos),
        .wave_prof (wave_prof),
        .p_obj     (p_obj),
        .score     (score),
        .health    (health),
        .p_rgb     (p_rgb),
        .d100      (d100),
        .d10       (d10),
        .d1        (d1)
    );

    always #5 vclock = ~vclock;             // 100 MHz

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the test sequence never finished", watchdog_ns);
        $display("tests failed");
        $fatal(1, "timeout");
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "first error, run stopped");
        end
    endtask

    // new pixel each falling edge, result two edges later
    task automatic drive_pixel(input string name, input int h, input int v);
        @(negedge vclock);
        if (exp_q.size() == 2) begin
            check_value(name, exp_q.pop_front(), p_rgb);
        end
        hcount = hpos_t'(h);
        vcount = vpos_t'(v);
        exp_q.push_back(model_pixel(h, v, int'(wave_prof), int'(health)));
    endtask

    task automatic flush_pixels(input string name);
        if (exp_q.size() == 1) begin
            @(negedge vclock);              // lone pixel still one edge short
        end
        while (exp_q.size() != 0) begin
            @(negedge vclock);
            check_value(name, exp_q.pop_front(), p_rgb);
        end
    endtask

    task automatic new_frame(input string name, input logic [1:0] new_health,
                             input vpos_t new_wave);
        flush_pixels(name);                 // in-flight pixels use the old state
        @(negedge vclock);
        health    = new_health;
        wave_prof = new_wave;
        vsync     = 1'b0;
        @(negedge vclock);
        vsync = 1'b1;
        repeat (2) @(negedge vclock);       // third edge after the fall
        model_frame(p_vpos, p_obj, score);
        check_value({name, " d100"}, model_digit(100), d100);
        check_value({name, " d10"}, model_digit(10), d10);
        check_value({name, " d1"}, model_digit(1), d1);
    endtask

    task automatic random_objects();
        for (int i = 0; i < n_objects; i++) begin
            p_obj[i].frame = 3'($urandom_range(0, 7));
            p_obj[i].id    = obj_id_e'($urandom_range(0, 3));  // unused ids too
            p_obj[i].x     = hpos_t'($urandom_range(0, 639));
            p_obj[i].y     = vpos_t'($urandom_range(0, 479));
            if ($urandom_range(0, 4) == 0) begin
                p_obj[i] = '0;
            end
        end
    endtask

    task automatic clear_objects();
        for (int i = 0; i < n_objects; i++) begin
            p_obj[i] = '0;
        end
    endtask

    // around a latched slot, edges included
    task automatic pick_near_object(output int h, output int v);
        int k;
        k = $urandom_range(0, n_objects - 1);
        h = int'(m_obj[k].x) + int'($urandom_range(0, 50)) - 5;
        v = int'(m_obj[k].y) + int'($urandom_range(0, 30)) - 5;
        if (h < 0) begin
            h = 0;
        end
        if (v < 0) begin
            v = 0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int h;
        int v;
        int k;
        int score_list [6] = '{0, 7, 999, 1000, 1023, 305};
        void'($urandom(91368));
        reset     = 1'b1;
        hcount    = '0;
        vcount    = '0;
        vsync     = 1'b1;                   // idle high
        p_vpos    = 10'd384;
        wave_prof = 10'd240;
        score     = '0;
        health    = '0;
        clear_objects();
        model_reset();

        // reset values
        repeat (4) @(negedge vclock);
        check_value("reset p_rgb", 0, p_rgb);
        check_value("reset d100", 0, d100);
        check_value("reset d10", 0, d10);
        check_value("reset d1", 0, d1);
        reset  = 1'b0;
        hcount = 11'd600;
        vcount = 10'd400;                   // below the wave, water
        exp_q.push_back(model_pixel(600, 400, int'(wave_prof), int'(health)));
        flush_pixels("first pixel after reset");

        // decimal digits, edge cases first
        for (int f = 0; f < score_frames; f++) begin
            score = (f < 6) ? 10'(score_list[f]) : 10'($urandom_range(0, 1023));
            new_frame("score digits", 2'($urandom_range(0, 3)), vpos_t'($urandom_range(0, 479)));
        end

        // objects and layer priority
        for (int f = 0; f < obj_frames; f++) begin
            random_objects();
            p_vpos = vpos_t'($urandom_range(0, 479));
            score  = 10'($urandom_range(0, 1023));
            new_frame("objects frame", 2'($urandom_range(0, 3)), vpos_t'($urandom_range(0, 599)));
            for (int p = 0; p < obj_pixels; p++) begin
                if ($urandom_range(0, 9) < 7) begin
                    pick_near_object(h, v);
                end else begin
                    h = $urandom_range(0, 799);
                    v = $urandom_range(0, 599);
                end
                drive_pixel("objects and priority", h, v);
            end
        end

        // hearts and score glyphs
        clear_objects();
        for (int f = 0; f < hud_frames; f++) begin
            p_vpos = vpos_t'($urandom_range(200, 440));   // player clear of the hud
            score  = 10'($urandom_range(0, 1023));
            new_frame("hud frame", 2'($urandom_range(0, 3)), vpos_t'($urandom_range(0, 599)));
            for (int p = 0; p < hud_pixels; p++) begin
                k = $urandom_range(0, 2);
                if ($urandom_range(0, 1) == 0) begin
                    h = int'(heart_x[k]) + int'($urandom_range(0, heart_w - 1));
                    v = int'(heart_y) + int'($urandom_range(0, heart_h - 1));
                end else begin
                    h = int'(digit_x[k]) + int'($urandom_range(0, digit_w - 1));
                    v = int'(digit_y) + int'($urandom_range(0, digit_h - 1));
                end
                drive_pixel("hud", h, v);
            end
        end

        // backdrop, parallax steps every 8 frames
        for (int f = 0; f < bg_frames; f++) begin
            p_vpos = 10'd440;
            new_frame("backdrop frame", 2'($urandom_range(0, 3)), vpos_t'($urandom_range(0, 599)));
            for (int p = 0; p < bg_pixels; p++) begin
                drive_pixel("backdrop and parallax", $urandom_range(200, 799),
                            $urandom_range(0, 599));
            end
        end

        // player palette follows anim_count
        for (int f = 0; f < anim_frames; f++) begin
            p_vpos = vpos_t'($urandom_range(0, 440));
            new_frame("player frame", 2'($urandom_range(0, 3)), vpos_t'($urandom_range(0, 599)));
            for (int p = 0; p < anim_pixels; p++) begin
                h = int'(player_x) + int'($urandom_range(0, player_w - 1));
                v = int'(p_vpos) + int'($urandom_range(0, player_h - 1));
                drive_pixel("player animation", h, v);
            end
        end

        flush_pixels("player animation");
        $display("all tests passed");
        $finish;
    end

endmodule

// File: include/digit_font.svh
// 3 wide by 5 high digit glyphs
// rows top first, bit 14 is the top-left cell
localparam logic [14:0] digit_font [10] = '{
    15'b111_101_101_101_111,    // 0
    15'b010_110_010_010_111,    // 1
    15'b111_001_111_100_111,    // 2
    15'b111_001_111_001_111,    // 3
    15'b101_101_111_001_001,    // 4
    15'b111_100_111_001_111,    // 5
    15'b111_100_111_101_111,    // 6
    15'b111_001_001_001_001,    // 7
    15'b111_101_111_101_111,    // 8
    15'b111_101_111_001_111     // 9
};

// glyph columns per row
localparam int digit_font_cols = 3;

// cell rows per glyph
localparam int digit_font_rows = 5;

// File: logic/backdrop.sv
`timescale 1ns/1ns

module backdrop
    import display_pkg::*;
(
    input  logic        vclock,
    input  logic        reset,
    input  hpos_t       hcount,
    input  vpos_t       vcount,
    input  vpos_t       wave_prof,          // wave height at this column
    input  logic [10:0] parallax_offset,
    output rgb_t        bg_rgb
);

    logic [9:0] scroll_x;                   // wraps at 1024

    assign scroll_x = hcount[9:0] + parallax_offset[9:0];

    // sky stripes above the wave, plain water below
    always_ff @(posedge vclock) begin
        if (reset) begin
            bg_rgb <= '0;
        end else if (vcount <= wave_prof) begin
            bg_rgb <= scroll_x[stripe_bit] ? sky_dark_rgb : sky_light_rgb;
        end else begin
            bg_rgb <= water_rgb;
        end
    end

endmodule

// File: logic/display_pkg.sv
package display_pkg;

    ////////////////////////////////////////////////////////////
    // pixel and coordinate types
    ////////////////////////////////////////////////////////////

    typedef logic [11:0] rgb_t;     // r, g, b nibbles; 0 is transparent
    typedef logic [10:0] hpos_t;
    typedef logic [9:0]  vpos_t;

    typedef enum logic [1:0] {
        obj_coin     = 2'd0,
        obj_shark    = 2'd1,
        obj_unused_2 = 2'd2,        // draws nothing
        obj_unused_3 = 2'd3         // draws nothing
    } obj_id_e;

    // one object slot, all zero means the slot is empty
    typedef struct packed {
        logic [2:0] frame;          // coin animation frame
        obj_id_e    id;
        hpos_t      x;
        vpos_t      y;
    } obj_word_t;

    localparam int n_objects = 5;   // default slot count

    ////////////////////////////////////////////////////////////
    // sprite geometry
    ////////////////////////////////////////////////////////////

    localparam hpos_t player_x       = 11'd10;
    localparam int    player_w       = 45;
    localparam int    player_h       = 40;
    localparam vpos_t player_reset_y = 10'd384;

    localparam int coin_w  = 15;
    localparam int coin_h  = 16;
    localparam int shark_w = 40;
    localparam int shark_h = 20;

    localparam int    heart_w    = 40;
    localparam int    heart_h    = 40;
    localparam hpos_t heart_x [3] = '{11'd20, 11'd80, 11'd140};
    localparam vpos_t heart_y    = 10'd20;

    localparam int    digit_w    = 15;
    localparam int    digit_h    = 25;
    localparam hpos_t digit_x [3] = '{11'd20, 11'd60, 11'd100};  // hundreds, tens, ones
    localparam vpos_t digit_y    = 10'd100;
    localparam int    glyph_cell = 5;                            // 5x5 pixels per font cell

    ////////////////////////////////////////////////////////////
    // colours
    ////////////////////////////////////////////////////////////

    localparam rgb_t player_palette [4] = '{12'hF80, 12'hFA2, 12'hFC4, 12'hFA2};
    localparam rgb_t coin_palette [8]   = '{12'hFD0, 12'hFE3, 12'hFF6, 12'hFE3,
                                            12'hFD0, 12'hEB0, 12'hD90, 12'hEB0};
    localparam rgb_t shark_rgb       = 12'h678;
    localparam rgb_t heart_full_rgb  = 12'hE12;
    localparam rgb_t heart_empty_rgb = 12'h433;
    localparam rgb_t digit_rgb       = 12'hFFF;
    localparam rgb_t sky_light_rgb   = 12'hBDF;
    localparam rgb_t sky_dark_rgb    = 12'h9BE;
    localparam rgb_t water_rgb       = 12'h00F;

    localparam int parallax_div = 8;    // frames per parallax step
    localparam int stripe_bit   = 5;    // 32-pixel sky stripes

    // true when (hc, vc) lies inside the w by h box at (x, y)
    function automatic logic in_box(hpos_t hc, vpos_t vc, hpos_t x, vpos_t y, int w, int h);
        return (int'(hc) >= int'(x)) && (int'(hc) < int'(x) + w) &&
               (int'(vc) >= int'(y)) && (int'(vc) < int'(y) + h);
    endfunction

endpackage

// File: logic/display_top.sv
`timescale 1ns/1ns

module display_top
    import display_pkg::*;
#(
    parameter int n_objects = display_pkg::n_objects
) (
    input  logic       reset,
    input  logic       vclock,
    input  hpos_t      hcount,              // 0 at left
    input  vpos_t      vcount,              // 0 at top
    input  logic       vsync,               // active low
    input  vpos_t      p_vpos,
    input  vpos_t      wave_prof,
    input  obj_word_t  p_obj [n_objects],
    input  logic [9:0] score,
    input  logic [1:0] health,
    output rgb_t       p_rgb,
    output logic [3:0] d100,
    output logic [3:0] d10,
    output logic [3:0] d1
);

    logic        frame_start;
    vpos_t       vpos;
    obj_word_t   obj [n_objects];           // latched object slots
    logic [9:0]  score_q;
    logic [4:0]  anim_count;
    logic [10:0] parallax_offset;

    // layer colours, one cycle after hcount/vcount
    rgb_t obj_coin_rgb [n_objects];
    rgb_t obj_shark_rgb [n_objects];
    rgb_t player_rgb;
    rgb_t heart_rgb;
    rgb_t digit_layer_rgb;
    rgb_t bg_rgb;

    ////////////////////////////////////////////////////////////
    // frame rate side
    ////////////////////////////////////////////////////////////

    frame_state #(.n_objects(n_objects)) i_frame_state (
        .vclock, .reset, .vsync, .p_vpos, .p_obj, .score,
        .frame_start, .vpos, .obj, .score_q, .anim_count, .parallax_offset
    );

    score_digits i_score_digits (
        .vclock, .reset, .frame_start, .score_q, .d100, .d10, .d1
    );

    ////////////////////////////////////////////////////////////
    // pixel rate side
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < n_objects; i++) begin : g_obj
        object_sprite i_object_sprite (
            .vclock, .reset, .hcount, .vcount,
            .obj         (obj[i]),
            .coin_rgb    (obj_coin_rgb[i]),
            .shark_rgb_q (obj_shark_rgb[i])
        );
    end

    hud_sprites i_hud_sprites (
        .vclock, .reset, .hcount, .vcount, .vpos, .anim_count, .health,
        .d100, .d10, .d1,
        .player_rgb, .heart_rgb,
        .digit_rgb_q (digit_layer_rgb)
    );

    backdrop i_backdrop (
        .vclock, .reset, .hcount, .vcount, .wave_prof, .parallax_offset, .bg_rgb
    );

    pixel_compositor #(.n_objects(n_objects)) i_pixel_compositor (
        .vclock, .reset, .player_rgb,
        .coin_rgb  (obj_coin_rgb),
        .shark_rgb (obj_shark_rgb),
        .heart_rgb,
        .digit_rgb (digit_layer_rgb),
        .bg_rgb, .p_rgb
    );

endmodule

// File: logic/frame_state.sv
`timescale 1ns/1ns

module frame_state
    import display_pkg::*;
#(
    parameter int n_objects = display_pkg::n_objects
) (
    input  logic        vclock,
    input  logic        reset,
    input  logic        vsync,                  // active low
    input  vpos_t       p_vpos,
    input  obj_word_t   p_obj [n_objects],
    input  logic [9:0]  score,
    output logic        frame_start,            // one cycle per frame
    output vpos_t       vpos,
    output obj_word_t   obj [n_objects],
    output logic [9:0]  score_q,
    output logic [4:0]  anim_count,
    output logic [10:0] parallax_offset
);

    localparam int pc_w = $clog2(parallax_div);

    logic            vsync_q;                   // previous vsync sample
    logic [pc_w-1:0] parallax_count;            // frames since last parallax step

    ////////////////////////////////////////////////////////////
    // vsync falling edge
    ////////////////////////////////////////////////////////////

    always_ff @(posedge vclock) begin
        if (reset) begin
            vsync_q     <= 1'b0;                // no strobe if vsync is low out of reset
            frame_start <= 1'b0;
        end else begin
            vsync_q     <= vsync;
            frame_start <= vsync_q & ~vsync;    // high then low
        end
    end

    ////////////////////////////////////////////////////////////
    // per-frame game state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge vclock) begin
        if (reset) begin
            vpos <= player_reset_y;
            for (int i = 0; i < n_objects; i++) begin
                obj[i] <= '0;                   // all slots empty
            end
            score_q         <= '0;
            anim_count      <= '0;
            parallax_count  <= '0;
            parallax_offset <= '0;
        end else if (frame_start) begin
            vpos       <= p_vpos;
            obj        <= p_obj;
            score_q    <= score;
            anim_count <= anim_count + 5'd1;    // top two bits pick the player frame
            // slow scroll, one pixel every parallax_div frames
            if (parallax_count == pc_w'(parallax_div - 1)) begin
                parallax_count  <= '0;
                parallax_offset <= parallax_offset + 11'd1;
            end else begin
                parallax_count <= parallax_count + 1'b1;
            end
        end
    end

    // strobe must come from a single edge, never a held level
    a_single_strobe: assert property (@(posedge vclock) disable iff (reset)
        frame_start |=> !frame_start);

endmodule

// File: logic/hud_sprites.sv
`timescale 1ns/1ns

module hud_sprites
    import display_pkg::*;
(
    input  logic       vclock,
    input  logic       reset,
    input  hpos_t      hcount,
    input  vpos_t      vcount,
    input  vpos_t      vpos,            // latched player height
    input  logic [4:0] anim_count,
    input  logic [1:0] health,          // straight from the game, not latched
    input  logic [3:0] d100,
    input  logic [3:0] d10,
    input  logic [3:0] d1,
    output rgb_t       player_rgb,
    output rgb_t       heart_rgb,
    output rgb_t       digit_rgb_q
);

    `include "digit_font.svh"

    logic [3:0] digit_val [3];          // same order as digit_x
    rgb_t       player_c;
    rgb_t       heart_c;
    rgb_t       digit_c;
    int         col;                    // font cell inside the glyph
    int         row;

    assign digit_val[0] = d100;
    assign digit_val[1] = d10;
    assign digit_val[2] = d1;

    ////////////////////////////////////////////////////////////
    // player, hearts, score glyphs
    ////////////////////////////////////////////////////////////

    always_comb begin
        col = 0;
        row = 0;

        // player frame steps every 8 frames
        player_c = in_box(hcount, vcount, player_x, vpos, player_w, player_h) ?
                   player_palette[anim_count[4:3]] : '0;

        heart_c = '0;
        for (int i = 0; i < 3; i++) begin
            if (in_box(hcount, vcount, heart_x[i], heart_y, heart_w, heart_h)) begin
                heart_c = (int'(health) > i) ? heart_full_rgb : heart_empty_rgb;
            end
        end

        digit_c = '0;
        for (int i = 0; i < 3; i++) begin
            if (in_box(hcount, vcount, digit_x[i], digit_y, digit_w, digit_h)) begin
                col = (int'(hcount) - int'(digit_x[i])) / glyph_cell;
                row = (int'(vcount) - int'(digit_y)) / glyph_cell;
                // bit 14 is top-left, walk down row by row
                if (digit_font[digit_val[i]][digit_font_cols * digit_font_rows - 1 -
                                             (digit_font_cols * row + col)]) begin
                    digit_c = digit_rgb;
                end
            end
        end
    end

    always_ff @(posedge vclock) begin
        if (reset) begin
            player_rgb  <= '0;
            heart_rgb   <= '0;
            digit_rgb_q <= '0;
        end else begin
            player_rgb  <= player_c;
            heart_rgb   <= heart_c;
            digit_rgb_q <= digit_c;    // unlit cells stay transparent
        end
    end

endmodule

// File: logic/object_sprite.sv
`timescale 1ns/1ns

module object_sprite
    import display_pkg::*;
(
    input  logic      vclock,
    input  logic      reset,
    input  hpos_t     hcount,
    input  vpos_t     vcount,
    input  obj_word_t obj,
    output rgb_t      coin_rgb,
    output rgb_t      shark_rgb_q
);

    int   box_w;        // box size for this kind, 0 for unused ids
    int   box_h;
    logic hit;          // pixel inside a live object's box

    // box size from the identity field
    always_comb begin
        box_w = 0;
        box_h = 0;
        case (obj.id)
            obj_coin: begin
                box_w = coin_w;
                box_h = coin_h;
            end
            obj_shark: begin
                box_w = shark_w;
                box_h = shark_h;
            end
            default: begin
                box_w = 0;      // zero size, never hit
                box_h = 0;
            end
        endcase
    end

    assign hit = (obj != '0) && in_box(hcount, vcount, obj.x, obj.y, box_w, box_h);

    always_ff @(posedge vclock) begin
        if (reset) begin
            coin_rgb    <= '0;
            shark_rgb_q <= '0;
        end else begin
            coin_rgb    <= (hit && obj.id == obj_coin) ? coin_palette[obj.frame] : '0;
            shark_rgb_q <= (hit && obj.id == obj_shark) ? shark_rgb : '0; // one colour for all
        end
    end

    // one slot is one kind at a time
    a_one_kind: assert property (@(posedge vclock) disable iff (reset)
        !((coin_rgb != '0) && (shark_rgb_q != '0)));

endmodule

// File: logic/pixel_compositor.sv
`timescale 1ns/1ns

module pixel_compositor
    import display_pkg::*;
#(
    parameter int n_objects = display_pkg::n_objects
) (
    input  logic vclock,
    input  logic reset,
    input  rgb_t player_rgb,
    input  rgb_t coin_rgb [n_objects],
    input  rgb_t shark_rgb [n_objects],
    input  rgb_t heart_rgb,
    input  rgb_t digit_rgb,
    input  rgb_t bg_rgb,
    output rgb_t p_rgb
);

    rgb_t next_rgb;

    ////////////////////////////////////////////////////////////
    // layer priority
    ////////////////////////////////////////////////////////////

    // lowest layer first, each nonzero layer covers what is below
    always_comb begin
        next_rgb = bg_rgb;                          // always opaque
        if (digit_rgb != '0) begin
            next_rgb = digit_rgb;
        end
        if (heart_rgb != '0) begin
            next_rgb = heart_rgb;
        end
        for (int i = n_objects - 1; i >= 0; i--) begin
            if (shark_rgb[i] != '0) begin
                next_rgb = shark_rgb[i];            // slot 0 ends on top
            end
        end
        for (int i = n_objects - 1; i >= 0; i--) begin
            if (coin_rgb[i] != '0) begin
                next_rgb = coin_rgb[i];             // coins over sharks
            end
        end
        if (player_rgb != '0) begin
            next_rgb = player_rgb;
        end
    end

    always_ff @(posedge vclock) begin
        if (reset) begin
            p_rgb <= '0;                            // black
        end else begin
            p_rgb <= next_rgb;
        end
    end

    // backdrop reaches the output two edges after reset drops
    a_opaque: assert property (@(posedge vclock) disable iff (reset)
        (!$past(reset) && !$past(reset, 2)) |-> (p_rgb != '0));

endmodule

// File: logic/score_digits.sv
`timescale 1ns/1ns

module score_digits (
    input  logic       vclock,
    input  logic       reset,
    input  logic       frame_start,
    input  logic [9:0] score_q,
    output logic [3:0] d100,
    output logic [3:0] d10,
    output logic [3:0] d1
);

    logic       load_q;     // frame_start delayed, score_q is new by then
    logic [9:0] clamped;    // 0 to 999

    assign clamped = (score_q > 10'd999) ? 10'd999 : score_q;

    // decimal split, once per frame
    always_ff @(posedge vclock) begin
        if (reset) begin
            load_q <= 1'b0;
            d100   <= '0;
            d10    <= '0;
            d1     <= '0;
        end else begin
            load_q <= frame_start;
            if (load_q) begin
                d100 <= 4'(clamped / 10'd100);
                d10  <= 4'((clamped / 10'd10) % 10'd10);
                d1   <= 4'(clamped % 10'd10);
            end
        end
    end

    // the font table only has glyphs 0 to 9
    a_decimal: assert property (@(posedge vclock) disable iff (reset)
        (d100 <= 4'd9) && (d10 <= 4'd9) && (d1 <= 4'd9));

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the display testbench, the log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_display \
    -Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/Vtb_display > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log
grep -q "tests failed" sim.log && { echo "RESULT: FAIL"; exit 1; } || true
grep -q "all tests passed" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }

// File: sources.f
+incdir+include
+incdir+bench
logic/display_pkg.sv
logic/frame_state.sv
logic/score_digits.sv
logic/object_sprite.sv
logic/hud_sprites.sv
logic/backdrop.sv
logic/pixel_compositor.sv
logic/display_top.sv
bench/tb_display.sv
